// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -Wno-fatal
TOP       ?= isqrt_tb
FILELIST  ?= isqrt_top.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$($(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/fixed_nr_stage.sv ====
`timescale 1ns/1ps
module fixed_nr_stage #(
    parameter int WIDTH = isqrt_pkg::WIDTH,
    parameter int MSB_WIDTH = isqrt_pkg::KZ_WIDTH,
    localparam logic [2*WIDTH-1:0] THREE_HALVES = (2 * WIDTH)'(3) << (WIDTH - 2)
) (
    input  logic                 clk,
    input  logic                 arst_n,
    // Reduced operand, Q1.(WIDTH-1).
    input  logic [WIDTH-1:0]     data_a,
    // Current guess, Q1.(WIDTH-1).
    input  logic [WIDTH-1:0]     data_b,
    input  logic [MSB_WIDTH-1:0] data_in_msb,
    input  logic                 data_in_valid,
    output logic                 data_in_ready,
    // Refined guess, Q1.(WIDTH-1) in the low bits.
    output logic [2*WIDTH-1:0]   data_out,
    output logic [MSB_WIDTH-1:0] data_out_msb,
    output logic [WIDTH-1:0]     data_out_x_reduced,
    output logic                 data_out_valid,
    input  logic                 data_out_ready
);
    localparam int STEP_WIDTH = 2 * WIDTH + WIDTH + WIDTH + MSB_WIDTH;

    logic [2*WIDTH-1:0]   guess_sq [2];
    logic [2*WIDTH-1:0]   half_prod [2];
    logic [2*WIDTH-1:0]   diff [2];
    logic [2*WIDTH-1:0]   refined;
    logic [WIDTH-1:0]     xr_q [1:3];
    logic [WIDTH-1:0]     guess_q [1:3];
    logic [MSB_WIDTH-1:0] msb_q [1:3];
    logic                 step_valid [1:3];
    logic                 step_ready [1:3];

    // y squared.
    assign guess_sq[0] = (data_b * data_b) >> (WIDTH - 1);

    skid_buffer #(
        .DATA_WIDTH(STEP_WIDTH)
    ) step0_reg (
        .clk           (clk),
        .arst_n        (arst_n),
        .data_in       ({guess_sq[0], data_a, data_b, data_in_msb}),
        .data_in_valid (data_in_valid),
        .data_in_ready (data_in_ready),
        .data_out      ({guess_sq[1], xr_q[1], guess_q[1], msb_q[1]}),
        .data_out_valid(step_valid[1]),
        .data_out_ready(step_ready[1])
    );

    // xr * y^2 / 2.
    assign half_prod[0] = ((xr_q[1] >> 1) * guess_sq[1]) >> (WIDTH - 1);

    skid_buffer #(
        .DATA_WIDTH(STEP_WIDTH)
    ) step1_reg (
        .clk           (clk),
        .arst_n        (arst_n),
        .data_in       ({half_prod[0], xr_q[1], guess_q[1], msb_q[1]}),
        .data_in_valid (step_valid[1]),
        .data_in_ready (step_ready[1]),
        .data_out      ({half_prod[1], xr_q[2], guess_q[2], msb_q[2]}),
        .data_out_valid(step_valid[2]),
        .data_out_ready(step_ready[2])
    );

    assign diff[0] = THREE_HALVES - half_prod[1];

    skid_buffer #(
        .DATA_WIDTH(STEP_WIDTH)
    ) step2_reg (
        .clk           (clk),
        .arst_n        (arst_n),
        .data_in       ({diff[0], xr_q[2], guess_q[2], msb_q[2]}),
        .data_in_valid (step_valid[2]),
        .data_in_ready (step_ready[2]),
        .data_out      ({diff[1], xr_q[3], guess_q[3], msb_q[3]}),
        .data_out_valid(step_valid[3]),
        .data_out_ready(step_ready[3])
    );

    assign refined = (guess_q[3] * diff[1]) >> (WIDTH - 1);

    skid_buffer #(
        .DATA_WIDTH(2 * WIDTH + WIDTH + MSB_WIDTH)
    ) step3_reg (
        .clk           (clk),
        .arst_n        (arst_n),
        .data_in       ({refined, xr_q[3], msb_q[3]}),
        .data_in_valid (step_valid[3]),
        .data_in_ready (step_ready[3]),
        .data_out      ({data_out, data_out_x_reduced, data_out_msb}),
        .data_out_valid(data_out_valid),
        .data_out_ready(data_out_ready)
    );

endmodule

// ==== hw/isqrt_denorm.sv ====
`timescale 1ns/1ps
module isqrt_denorm #(
    parameter int WIDTH = isqrt_pkg::WIDTH
) (
    input  logic             clk,
    input  logic             arst_n,
    input  isqrt_pkg::wide_t est,
    input  isqrt_pkg::kz_t   k_zero,
    input  logic             in_valid,
    output logic             in_ready,
    output isqrt_pkg::wide_t y,
    output logic             out_valid,
    input  logic             out_ready
);
    import isqrt_pkg::*;

    q1_t    est_sat;
    wide_t  widened;
    wide_t  y_next;
    shift_t k;
    logic   is_zero;

    assign k = k_zero[SHIFT_WIDTH-1:0];
    assign is_zero = k_zero[KZ_WIDTH-1];

    // Estimate stays below 2, the clamp only guards the last LSB.
    assign est_sat = (est[2*WIDTH-1:WIDTH] != '0) ? '1 : est[WIDTH-1:0];

    // Q1.(WIDTH-1) to Q1.(2*WIDTH-1).
    assign widened = {est_sat, {WIDTH{1'b0}}};

    assign y_next = is_zero ? '1 : (widened >> k);

    skid_buffer #(
        .DATA_WIDTH(2 * WIDTH)
    ) out_reg (
        .clk           (clk),
        .arst_n        (arst_n),
        .data_in       (y_next),
        .data_in_valid (in_valid),
        .data_in_ready (in_ready),
        .data_out      (y),
        .data_out_valid(out_valid),
        .data_out_ready(out_ready)
    );

endmodule

// ==== hw/isqrt_pkg.sv ====
package isqrt_pkg;

    // Operand width, also the fraction base of the refinement stages.
    localparam int WIDTH = 16;

    // Halved exponent k spans 1 to WIDTH/2.
    localparam int SHIFT_WIDTH = $clog2(WIDTH / 2 + 1);

    // Seed table index bits.
    localparam int SEED_BITS = 6;

    // Zero flag on top of k.
    localparam int KZ_WIDTH = SHIFT_WIDTH + 1;

    localparam int SEED_ENTRIES = 2 ** SEED_BITS;

    // Raw integer operand.
    typedef logic [WIDTH-1:0] operand_t;

    // Q1.(WIDTH-1) value.
    typedef logic [WIDTH-1:0] q1_t;

    // Double width product, also the Q1.(2*WIDTH-1) result.
    typedef logic [2*WIDTH-1:0] wide_t;

    // Halved exponent.
    typedef logic [SHIFT_WIDTH-1:0] shift_t;

    // Halved exponent with the zero flag as its top bit.
    typedef logic [KZ_WIDTH-1:0] kz_t;

endpackage

// ==== hw/isqrt_range_reduce.sv ====
`timescale 1ns/1ps
module isqrt_range_reduce #(
    parameter int WIDTH = isqrt_pkg::WIDTH
) (
    input  logic                clk,
    input  logic                arst_n,
    input  isqrt_pkg::operand_t x,
    input  logic                x_valid,
    output logic                x_ready,
    output isqrt_pkg::q1_t      xr,
    output isqrt_pkg::q1_t      seed,
    output isqrt_pkg::shift_t   k,
    output logic                is_zero,
    output logic                valid,
    input  logic                ready
);
    import isqrt_pkg::*;

    localparam int LEAD_BITS = $clog2(WIDTH);
    localparam int PAYLOAD_WIDTH = 2 * WIDTH + SHIFT_WIDTH + 1;

    logic [LEAD_BITS-1:0] lead;
    shift_t               k_next;
    operand_t             norm;
    q1_t                  xr_next;
    q1_t                  seed_next;
    logic                 zero_next;

    // Priority search, highest set bit wins.
    always_comb begin
        lead = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (x[i]) begin
                lead = LEAD_BITS'(i);
            end
        end
    end

    // Odd and even lead positions share k, the shift keeps an even parity.
    assign k_next = shift_t'(lead >> 1) + shift_t'(1);
    assign norm = x << (WIDTH - 2 * int'(k_next));
    assign xr_next = norm >> 1;
    assign zero_next = (x == '0);

    isqrt_seed_lut seed_lut_inst (
        .index(xr_next[WIDTH-2 -: SEED_BITS]),
        .seed (seed_next)
    );

    skid_buffer #(
        .DATA_WIDTH(PAYLOAD_WIDTH)
    ) out_reg (
        .clk           (clk),
        .arst_n        (arst_n),
        .data_in       ({xr_next, seed_next, k_next, zero_next}),
        .data_in_valid (x_valid),
        .data_in_ready (x_ready),
        .data_out      ({xr, seed, k, is_zero}),
        .data_out_valid(valid),
        .data_out_ready(ready)
    );

    a_normalized: assert property (@(posedge clk) disable iff (!arst_n)
        valid && !is_zero |-> !xr[WIDTH-1] && (xr[WIDTH-2 -: 2] != 2'b00))
        else $error("isqrt_range_reduce: reduced operand below 0.25");

endmodule

// ==== hw/isqrt_seed_lut.sv ====
`timescale 1ns/1ps
module isqrt_seed_lut (
    input  logic [isqrt_pkg::SEED_BITS-1:0] index,
    output isqrt_pkg::q1_t                  seed
);
    import isqrt_pkg::*;

    // First bin at or above 0.25.
    localparam int FIRST_BIN = SEED_ENTRIES / 4;

    function automatic longint unsigned int_sqrt(input longint unsigned n);
        longint unsigned root;
        longint unsigned trial;
        root = 0;
        for (int b = 31; b >= 0; b--) begin
            trial = root | (64'd1 << b);
            if (trial * trial <= n) begin
                root = trial;
            end
        end
        return root;
    endfunction

    // 1/sqrt at the bin center, one extra bit kept for rounding.
    function automatic q1_t bin_seed(input int bin);
        longint unsigned num;
        longint unsigned root;
        int              b;
        b = (bin < FIRST_BIN) ? FIRST_BIN : bin;
        num = (64'd1 << (2 * WIDTH + SEED_BITS + 1)) / longint'(2 * b + 1);
        root = (int_sqrt(num) + 64'd1) >> 1;
        // Clamp just below 2.
        if (root > (64'd1 << WIDTH) - 64'd1) begin
            root = (64'd1 << WIDTH) - 64'd1;
        end
        return q1_t'(root);
    endfunction

    q1_t table_q [SEED_ENTRIES];

    for (genvar i = 0; i < SEED_ENTRIES; i++) begin : g_bin
        localparam q1_t BIN_VALUE = bin_seed(i);
        assign table_q[i] = BIN_VALUE;
    end

    assign seed = table_q[index];

endmodule

// ==== hw/isqrt_top.sv ====
`timescale 1ns/1ps
module isqrt_top #(
    parameter int WIDTH = isqrt_pkg::WIDTH,
    parameter int NR_STAGES = 2
) (
    input  logic                clk,
    input  logic                arst_n,
    input  isqrt_pkg::operand_t x,
    input  logic                x_valid,
    output logic                x_ready,
    output isqrt_pkg::wide_t    y,
    output logic                y_valid,
    input  logic                y_ready
);
    import isqrt_pkg::*;

    shift_t red_k;
    logic   red_zero;

    // Index i feeds NR stage i; the last index feeds the denormalizer.
    q1_t    stage_a [NR_STAGES+1];
    q1_t    stage_b [NR_STAGES];
    kz_t    stage_msb [NR_STAGES+1];
    logic   stage_valid [NR_STAGES+1];
    logic   stage_ready [NR_STAGES+1];
    wide_t  stage_out [NR_STAGES];

    isqrt_range_reduce #(
        .WIDTH(WIDTH)
    ) range_reduce_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .x      (x),
        .x_valid(x_valid),
        .x_ready(x_ready),
        .xr     (stage_a[0]),
        .seed   (stage_b[0]),
        .k      (red_k),
        .is_zero(red_zero),
        .valid  (stage_valid[0]),
        .ready  (stage_ready[0])
    );

    assign stage_msb[0] = {red_zero, red_k};

    for (genvar i = 0; i < NR_STAGES; i++) begin : g_nr
        fixed_nr_stage #(
            .WIDTH    (WIDTH),
            .MSB_WIDTH(KZ_WIDTH)
        ) nr_stage_inst (
            .clk               (clk),
            .arst_n            (arst_n),
            .data_a            (stage_a[i]),
            .data_b            (stage_b[i]),
            .data_in_msb       (stage_msb[i]),
            .data_in_valid     (stage_valid[i]),
            .data_in_ready     (stage_ready[i]),
            .data_out          (stage_out[i]),
            .data_out_msb      (stage_msb[i+1]),
            .data_out_x_reduced(stage_a[i+1]),
            .data_out_valid    (stage_valid[i+1]),
            .data_out_ready    (stage_ready[i+1])
        );

        // Refined guess is below 2, so the low half carries it.
        if (i < NR_STAGES - 1) begin : g_link
            assign stage_b[i+1] = stage_out[i][WIDTH-1:0];
        end
    end

    isqrt_denorm #(
        .WIDTH(WIDTH)
    ) denorm_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .est      (stage_out[NR_STAGES-1]),
        .k_zero   (stage_msb[NR_STAGES]),
        .in_valid (stage_valid[NR_STAGES]),
        .in_ready (stage_ready[NR_STAGES]),
        .y        (y),
        .out_valid(y_valid),
        .out_ready(y_ready)
    );

endmodule

// ==== hw/skid_buffer.sv ====
`timescale 1ns/1ps
module skid_buffer #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [DATA_WIDTH-1:0] data_in,
    input  logic                  data_in_valid,
    output logic                  data_in_ready,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic                  data_out_valid,
    input  logic                  data_out_ready
);
    logic                  skid_valid;
    logic [DATA_WIDTH-1:0] skid_data;
    logic                  main_load;
    logic                  in_fire;

    // Main register refills when empty or drained this cycle.
    assign main_load = !data_out_valid || data_out_ready;
    assign data_in_ready = !skid_valid;
    assign in_fire = data_in_valid && data_in_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_out_valid <= 1'b0;
            skid_valid     <= 1'b0;
        end else if (main_load) begin
            data_out_valid <= skid_valid || data_in_valid;
            skid_valid     <= 1'b0;
        end else if (in_fire) begin
            skid_valid <= 1'b1;
        end
    end

    // Skid entry drains first to keep order.
    always_ff @(posedge clk) begin
        if (main_load) begin
            data_out <= skid_valid ? skid_data : data_in;
        end else if (in_fire) begin
            skid_data <= data_in;
        end
    end

    property p_hold_while_stalled;
        @(posedge clk) disable iff (!arst_n)
            data_out_valid && !data_out_ready |=> data_out_valid && $stable(data_out);
    endproperty

    a_hold_while_stalled: assert property (p_hold_while_stalled)
        else $error("skid_buffer: output changed while stalled");

    a_idle_in_reset: assert property (@(posedge clk) !arst_n |-> !data_out_valid)
        else $error("skid_buffer: output valid during reset");

endmodule

// ==== isqrt_top.f ====
hw/isqrt_pkg.sv
hw/skid_buffer.sv
hw/isqrt_seed_lut.sv
hw/isqrt_range_reduce.sv
hw/fixed_nr_stage.sv
hw/isqrt_denorm.sv
hw/isqrt_top.sv
testbench/isqrt_tb.sv

// ==== testbench/isqrt_tb.sv ====
`timescale 1ns/1ps
module isqrt_tb;
    import isqrt_pkg::*;

    localparam int  CLK_PERIOD = 40;
    localparam int  NR_STAGES = 2;
    localparam int  LATENCY = 2 + 4 * NR_STAGES;
    localparam int  NUM_RANDOM = 150;
    localparam int  NUM_STALL = 150;
    localparam int  NUM_SINGLE = 4;
    localparam int  NUM_BURST = 32;
    localparam int  TOTAL_ITEMS = NUM_RANDOM + WIDTH + 1 + 3 + NUM_STALL + NUM_SINGLE + NUM_BURST;
    localparam int  WATCHDOG_CYCLES = TOTAL_ITEMS * 40 + 2000;
    localparam real TOLERANCE = 2.0 ** (-(WIDTH - 4));
    localparam real Y_SCALE = 2.0 ** (2 * WIDTH - 1);

    logic     clk = 1'b0;
    logic     arst_n;
    operand_t x;
    logic     x_valid;
    logic     x_ready;
    wide_t    y;
    logic     y_valid;
    logic     y_ready;

    integer   seed = 32'ha4b3_f85a;
    logic     stall_mode;
    logic     timed_mode;
    int       cycle;
    int       sent_count;
    int       in_count;
    int       out_count;

    // Accepted operands, their accept cycles and timing flags, in order.
    operand_t exp_q [$];
    int       accept_q [$];
    bit       timed_q [$];

    logic     chk_valid;
    logic     chk_orphan;
    logic     chk_timed;
    operand_t chk_x;
    wide_t    chk_y;
    int       chk_latency;

    always #(CLK_PERIOD / 2) clk = ~clk;

    isqrt_top #(
        .WIDTH    (WIDTH),
        .NR_STAGES(NR_STAGES)
    ) isqrt_top_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .x      (x),
        .x_valid(x_valid),
        .x_ready(x_ready),
        .y      (y),
        .y_valid(y_valid),
        .y_ready(y_ready)
    );

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic flag_mismatch(input string msg);
        stop_run($sformatf("FAIL %0t: %s", $time, msg));
    endtask

    // Zero saturates, anything else is held to a relative bound on 1/sqrt(x).
    function automatic bit result_ok(input operand_t xv, input wide_t yv);
        real expected;
        real got;
        real xr;
        if (xv == '0) begin
            return yv == '1;
        end
        xr = xv;
        got = yv;
        got = got / Y_SCALE;
        expected = 1.0 / $sqrt(xr);
        return ((got > expected) ? got - expected : expected - got) <= TOLERANCE * expected;
    endfunction

    // Spread over all magnitudes by a random right shift.
    function automatic operand_t random_operand(input bit allow_zero);
        logic [31:0] r;
        operand_t    v;
        r = $random(seed);
        v = operand_t'(r) >> r[27:24];
        if (allow_zero && r[31:29] == 3'b000) begin
            v = '0;
        end else if (v == '0) begin
            v = operand_t'(1);
        end
        return v;
    endfunction

    task automatic send_one(input operand_t value);
        x = value;
        x_valid = 1'b1;
        while (!x_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        x_valid = 1'b0;
        sent_count++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_drained();
        while (out_count != in_count) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Scoreboard. Pops before pushing, results are checked one edge later.
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cycle       <= 0;
            in_count    <= 0;
            out_count   <= 0;
            chk_valid   <= 1'b0;
            chk_orphan  <= 1'b0;
            chk_timed   <= 1'b0;
            chk_x       <= '0;
            chk_y       <= '0;
            chk_latency <= 0;
        end else begin
            cycle      <= cycle + 1;
            chk_valid  <= 1'b0;
            chk_orphan <= 1'b0;
            if (y_valid && y_ready) begin
                out_count <= out_count + 1;
                if (exp_q.size() == 0) begin
                    chk_orphan <= 1'b1;
                end else begin
                    chk_valid   <= 1'b1;
                    chk_x       <= exp_q.pop_front();
                    chk_y       <= y;
                    chk_timed   <= timed_q.pop_front();
                    chk_latency <= cycle - accept_q.pop_front();
                end
            end
            if (x_valid && x_ready) begin
                in_count <= in_count + 1;
                exp_q.push_back(x);
                accept_q.push_back(cycle);
                timed_q.push_back(timed_mode);
            end
        end
    end

    // Output back-pressure. Decided at the edge, driven 1 ns later.
    initial begin
        logic next_ready;
        logic [31:0] r;
        forever begin
            @(posedge clk);
            r = $random(seed);
            next_ready = !stall_mode || r[0];
            #1;
            y_ready = next_ready;
        end
    end

    initial begin
        int gap;
        x = '0;
        x_valid = 1'b0;
        y_ready = 1'b1;
        arst_n = 1'b0;
        stall_mode = 1'b0;
        timed_mode = 1'b0;
        sent_count = 0;
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        idle_cycles(1);

        repeat (NUM_RANDOM) begin
            send_one(random_operand(1'b0));
        end
        // Every power of two covers both parities and every k.
        for (int i = 0; i < WIDTH; i++) begin
            send_one(operand_t'(1) << i);
        end
        send_one('1);
        send_one(operand_t'(5));
        send_one('0);
        send_one(operand_t'(7));
        wait_drained();

        stall_mode = 1'b1;
        repeat (NUM_STALL) begin
            gap = {$random(seed)} % 3;
            idle_cycles(gap);
            send_one(random_operand(1'b1));
        end
        stall_mode = 1'b0;
        wait_drained();

        timed_mode = 1'b1;
        repeat (NUM_SINGLE) begin
            send_one(random_operand(1'b0));
            wait_drained();
        end
        repeat (NUM_BURST) begin
            send_one(random_operand(1'b0));
        end
        wait_drained();
        timed_mode = 1'b0;

        idle_cycles(2);
        if (out_count != sent_count || exp_q.size() != 0) begin
            stop_run($sformatf("results lost or duplicated: %0d sent, %0d received",
                sent_count, out_count));
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_run("timeout: outputs stopped arriving");
    end

    a_accuracy: assert property (@(posedge clk) disable iff (!arst_n)
        chk_valid |-> result_ok(chk_x, chk_y))
        else flag_mismatch($sformatf("x=%0d gave y=%h, outside the bound",
            $sampled(chk_x), $sampled(chk_y)));

    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        chk_valid && chk_timed |-> chk_latency == LATENCY)
        else flag_mismatch($sformatf("latency %0d cycles, expected %0d",
            $sampled(chk_latency), LATENCY));

    a_no_orphan: assert property (@(posedge clk) disable iff (!arst_n) !chk_orphan)
        else stop_run("a result arrived with no input waiting for it");

    a_hold_stalled: assert property (@(posedge clk) disable iff (!arst_n)
        y_valid && !y_ready |=> y_valid && $stable(y))
        else flag_mismatch("y changed while the output was stalled");

    a_burst_ready: assert property (@(posedge clk) disable iff (!arst_n)
        timed_mode && x_valid |-> x_ready)
        else stop_run("input was stalled while the output was never stalled");

    a_reset_idle: assert property (@(posedge clk) !arst_n |-> !y_valid && x_ready)
        else flag_mismatch("handshake outputs not idle during reset");

    a_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !y_valid && x_ready)
        else flag_mismatch("handshake outputs not idle after reset");

endmodule
